// File: design/gmii_rx_pkg.sv
package gmii_rx_pkg;

	//////////////////////////////
	// Framing constants
	//////////////////////////////

	// Preamble filler and start of frame delimiter
	localparam logic [7:0] preamble_byte = 8'h55;
	localparam logic [7:0] sfd_byte = 8'hd5;

	// Reflected Ethernet CRC-32, shifted out LSB first
	localparam logic [31:0] crc_poly = 32'hedb88320;
	localparam logic [31:0] crc_init = 32'hffffffff;

	// Trailing FCS length in bytes
	localparam int unsigned fcs_bytes = 4;

	//////////////////////////////
	// Shared types
	//////////////////////////////

	typedef logic [7:0] byte_t;

	// First received octet sits in bits 31:24
	typedef logic [31:0] word_t;

	typedef logic [31:0] count_t;

	// GMII receive side as seen from the PHY
	typedef struct packed {
		logic en;
		logic er;
		logic dvalid;
		byte_t data;
	} gmii_rx_t;

	// One frame byte after preamble stripping
	typedef struct packed {
		logic sof;
		logic valid;
		logic eof;
		byte_t data;
	} rx_byte_t;

	// Packed payload word, bytes_valid runs 1 to 4
	typedef struct packed {
		logic data_valid;
		logic [2:0] bytes_valid;
		word_t data;
	} rx_word_t;

	// Frame interface towards the upper layer
	typedef struct packed {
		logic start;
		logic data_valid;
		logic [2:0] bytes_valid;
		word_t data;
		logic commit;
		logic drop;
	} rx_bus_t;

	typedef struct packed {
		count_t rx_frames;
		count_t rx_crc_err;
	} rx_perf_t;

endpackage

// File: design/rx_preamble_detect.sv
module rx_preamble_detect (
	input logic gmii_rx_clk,
	input logic rst_n,
	input gmii_rx_pkg::gmii_rx_t gmii_rx,
	output gmii_rx_pkg::rx_byte_t rx_byte
);

	typedef enum logic [1:0] {
		st_idle,
		st_preamble,
		st_frame,
		st_discard
	} state_t;

	state_t state;

	//////////////////////////////
	// Frame state machine
	//////////////////////////////

	always_ff @(posedge gmii_rx_clk) begin
		if (!rst_n) begin
			state <= st_idle;
			rx_byte <= '0;
		end else begin
			// Strobes are single cycle pulses
			rx_byte.sof <= 1'b0;
			rx_byte.valid <= 1'b0;
			rx_byte.eof <= 1'b0;
			rx_byte.data <= gmii_rx.data;

			// Cycles without a byte strobe carry nothing
			if (gmii_rx.dvalid) begin
				case (state)
					st_idle: begin
						// Only a clean 0x55 may open a preamble
						if (gmii_rx.en) begin
							if ((gmii_rx.data == gmii_rx_pkg::preamble_byte) && !gmii_rx.er) begin
								state <= st_preamble;
							end else begin
								state <= st_discard;
							end
						end
					end

					st_preamble: begin
						// Truncated before SFD, nobody was told so nobody needs to know
						if (!gmii_rx.en) begin
							state <= st_idle;
						end else if (gmii_rx.data == gmii_rx_pkg::sfd_byte) begin
							rx_byte.sof <= 1'b1;
							state <= st_frame;
						end else if (gmii_rx.data != gmii_rx_pkg::preamble_byte) begin
							state <= st_discard;
						end
					end

					st_frame: begin
						// Every byte after the SFD goes downstream, FCS included
						if (gmii_rx.en) begin
							rx_byte.valid <= 1'b1;
						end else begin
							rx_byte.eof <= 1'b1;
							state <= st_idle;
						end
					end

					st_discard: begin
						// Sit out the rest of a broken burst
						if (!gmii_rx.en) begin
							state <= st_idle;
						end
					end

					default: begin
						state <= st_idle;
					end
				endcase
			end
		end
	end

endmodule

// File: design/rx_word_packer.sv
module rx_word_packer (
	input logic gmii_rx_clk,
	input logic rst_n,
	input gmii_rx_pkg::rx_byte_t rx_byte,
	output gmii_rx_pkg::rx_word_t rx_word,
	output gmii_rx_pkg::word_t fcs_held
);

	// Holdback of the four newest bytes, newest in bits 7:0
	gmii_rx_pkg::word_t hold;
	logic [2:0] fill;

	// Word under assembly and next free byte slot
	gmii_rx_pkg::word_t asm_word;
	logic [1:0] pos;

	logic word_valid;
	logic [2:0] word_bytes;
	gmii_rx_pkg::word_t word_data;

	// Oldest byte leaves the holdback once it is full
	logic spill;
	gmii_rx_pkg::byte_t spill_byte;

	assign spill = rx_byte.valid && (fill == gmii_rx_pkg::fcs_bytes);
	assign spill_byte = hold[31:24];

	//////////////////////////////
	// Control
	//////////////////////////////

	always_ff @(posedge gmii_rx_clk) begin
		if (!rst_n) begin
			fill <= '0;
			pos <= '0;
			word_valid <= 1'b0;
			word_bytes <= '0;
		end else begin
			word_valid <= 1'b0;
			word_bytes <= '0;
			if (rx_byte.sof) begin
				fill <= '0;
				pos <= '0;
			end else if (spill) begin
				pos <= pos + 2'd1;
				// Fourth slot filled, word is complete
				if (pos == 2'd3) begin
					word_valid <= 1'b1;
					word_bytes <= 3'd4;
				end
			end else if (rx_byte.valid) begin
				fill <= fill + 3'd1;
			end else if (rx_byte.eof && (pos != 2'd0)) begin
				// Leftover data bytes, the holdback keeps the FCS
				word_valid <= 1'b1;
				word_bytes <= {1'b0, pos};
			end
		end
	end

	//////////////////////////////
	// Data path
	//////////////////////////////

	always_ff @(posedge gmii_rx_clk) begin
		if (rx_byte.sof) begin
			hold <= '0;
			asm_word <= '0;
		end else if (rx_byte.valid) begin
			hold <= {hold[23:0], rx_byte.data};
			if (spill) begin
				if (pos == 2'd3) begin
					word_data <= {asm_word[31:8], spill_byte};
					asm_word <= '0;
				end else begin
					asm_word[8 * (3 - pos) +: 8] <= spill_byte;
				end
			end
		end else if (rx_byte.eof) begin
			// Unused low bytes are still zero
			word_data <= asm_word;
		end
	end

	assign rx_word = '{data_valid: word_valid, bytes_valid: word_bytes, data: word_data};

	// After the last byte the holdback is exactly the FCS
	assign fcs_held = hold;

endmodule

// File: design/rx_fcs_check.sv
module rx_fcs_check (
	input logic gmii_rx_clk,
	input logic rst_n,
	input gmii_rx_pkg::rx_byte_t rx_byte,
	output gmii_rx_pkg::word_t crc_fcs
);

	// Running CRC and its values before each of the last four bytes
	gmii_rx_pkg::word_t crc;
	gmii_rx_pkg::word_t hist [4];
	gmii_rx_pkg::word_t oldest;

	// One byte of the reflected CRC-32, LSB first
	function automatic gmii_rx_pkg::word_t crc_step(
		input gmii_rx_pkg::word_t crc_in,
		input gmii_rx_pkg::byte_t din
	);
		gmii_rx_pkg::word_t c;
		c = crc_in ^ {24'h0, din};
		for (int i = 0; i < 8; i++) begin
			if (c[0]) begin
				c = (c >> 1) ^ gmii_rx_pkg::crc_poly;
			end else begin
				c = c >> 1;
			end
		end
		return c;
	endfunction

	//////////////////////////////
	// CRC and history
	//////////////////////////////

	always_ff @(posedge gmii_rx_clk) begin
		if (!rst_n || rx_byte.sof) begin
			crc <= gmii_rx_pkg::crc_init;
			for (int i = 0; i < 4; i++) begin
				hist[i] <= gmii_rx_pkg::crc_init;
			end
		end else if (rx_byte.valid) begin
			// Steps per accepted byte, so strobe gaps do not matter
			crc <= crc_step(crc, rx_byte.data);
			hist[0] <= crc;
			hist[1] <= hist[0];
			hist[2] <= hist[1];
			hist[3] <= hist[2];
		end
	end

	// CRC over everything except the trailing FCS
	assign oldest = hist[3];

	// Complement, then low byte goes first on the wire
	assign crc_fcs = ~{oldest[7:0], oldest[15:8], oldest[23:16], oldest[31:24]};

endmodule

// File: design/rx_frame_judge.sv
module rx_frame_judge (
	input logic gmii_rx_clk,
	input logic rst_n,
	input gmii_rx_pkg::rx_byte_t rx_byte,
	input gmii_rx_pkg::rx_word_t rx_word,
	input gmii_rx_pkg::word_t fcs_held,
	input gmii_rx_pkg::word_t crc_fcs,
	output gmii_rx_pkg::rx_bus_t rx_bus,
	output gmii_rx_pkg::rx_perf_t perf
);

	// Frame length, saturates once an FCS worth of bytes arrived
	logic [2:0] byte_cnt;

	// Verdict taken at eof, published one cycle later
	logic judge_pend;
	logic judge_ok;

	logic bus_start;
	logic bus_valid;
	logic [2:0] bus_bytes;
	gmii_rx_pkg::word_t bus_data;
	logic bus_commit;
	logic bus_drop;

	always_ff @(posedge gmii_rx_clk) begin
		if (!rst_n) begin
			byte_cnt <= '0;
			judge_pend <= 1'b0;
			judge_ok <= 1'b0;
			bus_start <= 1'b0;
			bus_valid <= 1'b0;
			bus_bytes <= '0;
			bus_commit <= 1'b0;
			bus_drop <= 1'b0;
			perf <= '0;
		end else begin
			bus_start <= rx_byte.sof;
			bus_valid <= rx_word.data_valid;
			bus_bytes <= rx_word.bytes_valid;
			if (rx_byte.sof) begin
				byte_cnt <= '0;
			end else if (rx_byte.valid && (byte_cnt != gmii_rx_pkg::fcs_bytes)) begin
				byte_cnt <= byte_cnt + 3'd1;
			end
			// Runts never carry a full FCS
			judge_pend <= rx_byte.eof;
			judge_ok <= (byte_cnt == gmii_rx_pkg::fcs_bytes) && (crc_fcs == fcs_held);
			bus_commit <= judge_pend && judge_ok;
			bus_drop <= judge_pend && !judge_ok;
			// Counters
			if (bus_commit) begin
				perf.rx_frames <= perf.rx_frames + 32'd1;
			end
			if (bus_drop) begin
				perf.rx_crc_err <= perf.rx_crc_err + 32'd1;
			end
		end
	end

	always_ff @(posedge gmii_rx_clk) begin
		bus_data <= rx_word.data;
	end

	assign rx_bus = '{start: bus_start, data_valid: bus_valid, bytes_valid: bus_bytes,
		data: bus_data, commit: bus_commit, drop: bus_drop};

endmodule

// File: design/gmii_rx_mac.sv
module gmii_rx_mac (
	input logic gmii_rx_clk,
	input logic rst_n,
	input gmii_rx_pkg::gmii_rx_t gmii_rx,
	output gmii_rx_pkg::rx_bus_t rx_bus,
	output gmii_rx_pkg::rx_perf_t perf
);

	gmii_rx_pkg::rx_byte_t rx_byte;
	gmii_rx_pkg::rx_word_t rx_word;
	gmii_rx_pkg::word_t fcs_held;
	gmii_rx_pkg::word_t crc_fcs;

	// Strip preamble and SFD
	rx_preamble_detect u_preamble_detect (
		.gmii_rx_clk(gmii_rx_clk),
		.rst_n(rst_n),
		.gmii_rx(gmii_rx),
		.rx_byte(rx_byte)
	);

	// Word packing and CRC run in parallel on the same bytes
	rx_word_packer u_word_packer (
		.gmii_rx_clk(gmii_rx_clk),
		.rst_n(rst_n),
		.rx_byte(rx_byte),
		.rx_word(rx_word),
		.fcs_held(fcs_held)
	);

	rx_fcs_check u_fcs_check (
		.gmii_rx_clk(gmii_rx_clk),
		.rst_n(rst_n),
		.rx_byte(rx_byte),
		.crc_fcs(crc_fcs)
	);

	// Final verdict and counters
	rx_frame_judge u_frame_judge (
		.gmii_rx_clk(gmii_rx_clk),
		.rst_n(rst_n),
		.rx_byte(rx_byte),
		.rx_word(rx_word),
		.fcs_held(fcs_held),
		.crc_fcs(crc_fcs),
		.rx_bus(rx_bus),
		.perf(perf)
	);

endmodule

// File: tb/tb_gmii_rx_tasks.svh
`ifndef tb_gmii_rx_tasks_svh
`define tb_gmii_rx_tasks_svh

//////////////////////////////
// Stimulus helpers
//////////////////////////////

// Fibonacci LFSR x^16 + x^14 + x^13 + x^11, one shift per bit
function automatic logic lfsr_next_bit();
	logic fb;
	fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
	lfsr_state = {lfsr_state[14:0], fb};
	return fb;
endfunction

function automatic logic [7:0] random_byte();
	logic [7:0] b;
	for (int i = 0; i < 8; i++) begin
		b[i] = lfsr_next_bit();
	end
	return b;
endfunction

// Ethernet FCS, bit serial, LSB of each byte first
function automatic logic [31:0] reference_crc(input byte_q_t msg);
	logic [31:0] c;
	logic fb;
	c = 32'hffffffff;
	foreach (msg[n]) begin
		for (int k = 0; k < 8; k++) begin
			fb = c[0] ^ msg[n][k];
			c = c >> 1;
			if (fb) begin
				c = c ^ 32'hedb88320;
			end
		end
	end
	return ~c;
endfunction

// Seven 0x55, SFD, payload, FCS low byte first; flip_bit below 0 keeps the FCS good
function automatic byte_q_t build_frame(input byte_q_t payload, input int flip_bit);
	byte_q_t burst;
	logic [31:0] fcs;
	fcs = reference_crc(payload);
	if (flip_bit >= 0) begin
		fcs[flip_bit] = ~fcs[flip_bit];
	end
	for (int i = 0; i < 7; i++) begin
		burst.push_back(8'h55);
	end
	burst.push_back(8'hd5);
	foreach (payload[i]) begin
		burst.push_back(payload[i]);
	end
	for (int i = 0; i < 4; i++) begin
		burst.push_back(fcs[8 * i +: 8]);
	end
	return burst;
endfunction

// gap - 1 idle strobes, then one cycle with dvalid high
task automatic drive_byte(input logic en, input logic er, input logic [7:0] data,
	input int gap);
	for (int i = 1; i < gap; i++) begin
		@(negedge gmii_rx_clk);
		gmii_rx.dvalid = 1'b0;
		gmii_rx.er = 1'b0;
	end
	@(negedge gmii_rx_clk);
	gmii_rx.en = en;
	gmii_rx.er = er;
	gmii_rx.dvalid = 1'b1;
	gmii_rx.data = data;
endtask

task automatic drive_frame(input byte_q_t burst, input logic first_er, input int gap);
	foreach (burst[i]) begin
		drive_byte(1'b1, first_er && (i == 0), burst[i], gap);
	end
	// en low with dvalid closes the burst, bus then stays idle
	drive_byte(1'b0, 1'b0, 8'h00, gap);
endtask

//////////////////////////////
// Checking helpers
//////////////////////////////

task automatic note_mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
	$display("MISMATCH at %0t: %s expected %h seen %h", $time, name, exp, got);
	mismatch_count++;
endtask

task automatic note_failure(input string msg);
	$display("ERROR at %0t: %s", $time, msg);
	failure_count++;
endtask

// Rising edge, so the falling-edge monitor never races the clear
task automatic clear_monitor();
	@(posedge gmii_rx_clk);
	seen_data.delete();
	seen_bytes.delete();
	seen_starts = 0;
	seen_commits = 0;
	seen_drops = 0;
	words_at_end = 0;
	word_with_verdict = 1'b0;
endtask

task automatic wait_frame_end(input int limit);
	int waited;
	waited = 0;
	while (((seen_commits + seen_drops) == 0) && (waited < limit)) begin
		@(posedge gmii_rx_clk);
		waited++;
	end
	if ((seen_commits + seen_drops) == 0) begin
		note_failure("no commit or drop pulse after the end of the frame");
	end
	// Room for stray pulses after the verdict
	repeat (4) @(posedge gmii_rx_clk);
endtask

// Words are payload in order, first byte on top, unused bytes zero
task automatic check_frame(input byte_q_t payload, input logic expect_commit);
	int n_words;
	logic [31:0] exp_word;
	logic [2:0] exp_bytes;
	n_words = (payload.size() + 3) / 4;
	if (seen_starts != 1) begin
		note_failure($sformatf("expected one start pulse, saw %0d", seen_starts));
	end
	if (seen_data.size() != n_words) begin
		note_failure($sformatf("expected %0d words, saw %0d", n_words, seen_data.size()));
	end
	for (int w = 0; (w < n_words) && (w < seen_data.size()); w++) begin
		exp_word = '0;
		exp_bytes = '0;
		for (int b = 0; b < 4; b++) begin
			if ((4 * w + b) < payload.size()) begin
				exp_word[31 - 8 * b -: 8] = payload[4 * w + b];
				exp_bytes++;
			end
		end
		if (seen_data[w] !== exp_word) begin
			note_mismatch($sformatf("rx_bus.data word %0d", w), exp_word, seen_data[w]);
		end
		if (seen_bytes[w] !== exp_bytes) begin
			note_mismatch($sformatf("rx_bus.bytes_valid word %0d", w), exp_bytes, seen_bytes[w]);
		end
	end
	if (words_at_end != n_words) begin
		note_failure("not all words arrived by the commit or drop pulse");
	end
	// A short last word leaves the packer together with the verdict
	if (((payload.size() % 4) != 0) && (word_with_verdict !== 1'b1)) begin
		note_failure("partial last word did not arrive with commit or drop");
	end
	if (expect_commit) begin
		expected_commits++;
		if ((seen_commits != 1) || (seen_drops != 0)) begin
			note_failure($sformatf("good frame gave %0d commits and %0d drops",
				seen_commits, seen_drops));
		end
	end else begin
		expected_drops++;
		if ((seen_drops != 1) || (seen_commits != 0)) begin
			note_failure($sformatf("bad frame gave %0d commits and %0d drops",
				seen_commits, seen_drops));
		end
	end
endtask

// Frame never reaches the SFD, so the bus stays quiet
task automatic expect_silence(input byte_q_t burst, input logic first_er);
	clear_monitor();
	drive_frame(burst, first_er, 1);
	// Any strobe would land within three cycles of the en-low sample
	repeat (8) @(posedge gmii_rx_clk);
	if ((seen_starts + seen_data.size() + seen_commits + seen_drops) != 0) begin
		note_failure("rx_bus strobe seen for a frame without SFD");
	end
endtask

//////////////////////////////
// Directed tests
//////////////////////////////

task automatic good_frame_whole_words();
	byte_q_t payload;
	for (int i = 0; i < 64; i++) begin
		payload.push_back(random_byte());
	end
	first_payload = payload;
	clear_monitor();
	drive_frame(build_frame(payload, -1), 1'b0, 1);
	wait_frame_end(40);
	check_frame(payload, 1'b1);
endtask

task automatic good_frame_partial_words();
	byte_q_t payload;
	for (int len = 61; len <= 63; len++) begin
		payload.delete();
		for (int i = 0; i < len; i++) begin
			payload.push_back(random_byte());
		end
		clear_monitor();
		drive_frame(build_frame(payload, -1), 1'b0, 1);
		wait_frame_end(40);
		check_frame(payload, 1'b1);
	end
endtask

task automatic bad_fcs_frame();
	byte_q_t payload;
	for (int i = 0; i < 64; i++) begin
		payload.push_back(random_byte());
	end
	clear_monitor();
	drive_frame(build_frame(payload, 13), 1'b0, 1);
	wait_frame_end(40);
	check_frame(payload, 1'b0);
endtask

task automatic frames_without_sfd();
	byte_q_t payload;
	byte_q_t good;
	byte_q_t burst;
	for (int i = 0; i < 16; i++) begin
		payload.push_back(random_byte());
	end
	good = build_frame(payload, -1);
	// Wrong first byte
	burst = good;
	burst[0] = 8'h5d;
	expect_silence(burst, 1'b0);
	// er on the first byte
	expect_silence(good, 1'b1);
	// Broken preamble
	burst = good;
	burst[3] = 8'h54;
	expect_silence(burst, 1'b0);
	// en falls after four preamble bytes
	burst.delete();
	for (int i = 0; i < 4; i++) begin
		burst.push_back(8'h55);
	end
	expect_silence(burst, 1'b0);
endtask

// 10/100 pacing, one byte strobe in ten cycles
task automatic frame_with_dvalid_gaps();
	clear_monitor();
	drive_frame(build_frame(first_payload, -1), 1'b0, 10);
	wait_frame_end(40);
	check_frame(first_payload, 1'b1);
endtask

task automatic perf_counters_match();
	@(negedge gmii_rx_clk);
	if (perf.rx_frames !== expected_commits) begin
		note_mismatch("perf.rx_frames", expected_commits, perf.rx_frames);
	end
	if (perf.rx_crc_err !== expected_drops) begin
		note_mismatch("perf.rx_crc_err", expected_drops, perf.rx_crc_err);
	end
endtask

`endif

// File: tb/tb_gmii_rx_mac.sv
module tb_gmii_rx_mac;

	//////////////////////////////
	// Run length
	//////////////////////////////

	localparam int clk_period = 20;
	localparam int reset_cycles = 4;

	// Longest frame: preamble and SFD, payload, FCS and the en-low sample
	localparam int frame_cycles = 8 + 64 + 4 + 1;

	// Monitor clear, verdict latency and trailing idle per frame
	localparam int settle_cycles = 20;

	// Nine frames at full rate, one frame at one byte in ten
	localparam int run_cycles = reset_cycles + 9 * (frame_cycles + settle_cycles)
		+ 10 * frame_cycles + settle_cycles;
	localparam int watchdog_time = 2 * run_cycles * clk_period;

	typedef logic [7:0] byte_q_t [$];

	logic gmii_rx_clk;
	logic rst_n;
	gmii_rx_pkg::gmii_rx_t gmii_rx;
	gmii_rx_pkg::rx_bus_t rx_bus;
	gmii_rx_pkg::rx_perf_t perf;

	// Payload generator state
	logic [15:0] lfsr_state;

	int mismatch_count;
	int failure_count;

	// What the monitor saw since the last clear
	logic [31:0] seen_data [$];
	logic [2:0] seen_bytes [$];
	int seen_starts;
	int seen_commits;
	int seen_drops;
	int words_at_end;
	logic word_with_verdict;

	// Verdicts the tests asked for, compared with perf at the end
	int expected_commits;
	int expected_drops;

	// Payload of the first good frame, resent with dvalid gaps
	byte_q_t first_payload;

	gmii_rx_mac u_dut (
		.gmii_rx_clk(gmii_rx_clk),
		.rst_n(rst_n),
		.gmii_rx(gmii_rx),
		.rx_bus(rx_bus),
		.perf(perf)
	);

	`include "tb_gmii_rx_tasks.svh"

	initial begin
		gmii_rx_clk = 1'b0;
		forever begin
			#(clk_period / 2) gmii_rx_clk = ~gmii_rx_clk;
		end
	end

	//////////////////////////////
	// Monitor
	//////////////////////////////

	// Outputs are registered, so the falling edge sees settled values
	always @(negedge gmii_rx_clk) begin
		if (rx_bus.start) begin
			seen_starts++;
		end
		if (rx_bus.data_valid) begin
			seen_data.push_back(rx_bus.data);
			seen_bytes.push_back(rx_bus.bytes_valid);
		end
		// Partial word shares the cycle with the verdict
		if (rx_bus.commit || rx_bus.drop) begin
			words_at_end = seen_data.size();
			word_with_verdict = rx_bus.data_valid;
		end
		if (rx_bus.commit) begin
			seen_commits++;
		end
		if (rx_bus.drop) begin
			seen_drops++;
		end
	end

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin
		rst_n = 1'b0;
		gmii_rx = '0;
		lfsr_state = 16'd57272;
		mismatch_count = 0;
		failure_count = 0;
		expected_commits = 0;
		expected_drops = 0;
		clear_monitor();
		repeat (reset_cycles) @(negedge gmii_rx_clk);
		rst_n = 1'b1;

		good_frame_whole_words();
		good_frame_partial_words();
		bad_fcs_frame();
		frames_without_sfd();
		frame_with_dvalid_gaps();
		perf_counters_match();

		$display("Mismatches %0d, other failures %0d", mismatch_count, failure_count);
		if ((mismatch_count + failure_count) == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	// Hard stop if a test hangs
	initial begin
		#(watchdog_time);
		$display("Watchdog expired at %0t, the tests did not finish", $time);
		$display("Errors found");
		$finish;
	end

endmodule

// File: build.f
+incdir+tb
design/gmii_rx_pkg.sv
design/rx_preamble_detect.sv
design/rx_word_packer.sv
design/rx_fcs_check.sv
design/rx_frame_judge.sv
design/gmii_rx_mac.sv
tb/tb_gmii_rx_mac.sv

// File: Bender.yml
package:
  name: gmii_rx_mac

sources:
  - design/gmii_rx_pkg.sv
  - design/rx_preamble_detect.sv
  - design/rx_word_packer.sv
  - design/rx_fcs_check.sv
  - design/rx_frame_judge.sv
  - design/gmii_rx_mac.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_gmii_rx_mac.sv
